//--- design/npu_pkg.sv
`default_nettype none

`include "npu_defs_defs.svh"

package npu_pkg;

    // One signed vector element
    typedef logic signed [`NPU_DATA_WIDTH-1:0] elem_t;

    // One tile word
    // Memory and host see the flat raw word
    // Activation and masking work on the element view
    typedef union packed {
        logic [`NPU_TILE_WIDTH-1:0]     raw;
        elem_t [`NPU_TILE_ELEMS-1:0]    elems;
    } tile_t;

    // Buffer number
    typedef logic [$clog2(`NPU_NUM_BUFFERS)-1:0] buf_id_t;

    // Tile position inside one buffer
    typedef logic [$clog2(`NPU_TILES_PER_BUF)-1:0] tile_idx_t;

    // Vector length in elements, 0 to 1023
    typedef logic [$clog2(`NPU_MAX_ELEMS)-1:0] vec_len_t;

endpackage

`default_nettype wire

//--- design/relu.sv
`timescale 1ns/1ps
`default_nettype none

`include "npu_defs_defs.svh"

// Element-wise max(0, x) over one tile, purely combinational
module relu (
    input  npu_pkg::tile_t in_tile,
    output npu_pkg::tile_t out_tile
);
    import npu_pkg::*;

    always_comb begin
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            // Sign bit set means negative, clamp to zero
            if (in_tile.elems[i][`NPU_DATA_WIDTH-1]) begin
                out_tile.elems[i] = '0;
            end else begin
                out_tile.elems[i] = in_tile.elems[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/relu_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

// Vector activation engine top
// Execution unit and vector memory share one tile bus
// Host side goes straight to the memory
module relu_accel_top (
    input  logic                clk,
    input  logic                rst,

    // Operation control
    input  logic                start,
    input  npu_pkg::buf_id_t    x_buffer_id,
    input  npu_pkg::buf_id_t    dest_buffer_id,
    input  npu_pkg::vec_len_t   length,
    output logic                done,
    output logic                busy,

    // Host write port
    input  logic                host_wr_en,
    input  npu_pkg::buf_id_t    host_wr_buf,
    input  npu_pkg::tile_idx_t  host_wr_tile,
    input  npu_pkg::tile_t      host_wr_data,

    // Host read port, one-cycle latency
    input  logic                host_rd_en,
    input  npu_pkg::buf_id_t    host_rd_buf,
    input  npu_pkg::tile_idx_t  host_rd_tile,
    output npu_pkg::tile_t      host_rd_data,
    output logic                host_rd_valid
);

    // Engine to memory tile bus
    vec_buf_if buf_bus (
        .clk (clk)
    );

    // ReLU sequencer
    relu_execution exec_unit (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .x_buffer_id    (x_buffer_id),
        .dest_buffer_id (dest_buffer_id),
        .length         (length),
        .done           (done),
        .busy           (busy),
        .mem            (buf_bus.engine)
    );

    // Banked vector memory
    vector_buffer vbuf (
        .clk           (clk),
        .rst           (rst),
        .mem           (buf_bus.memory),
        .host_wr_en    (host_wr_en),
        .host_wr_buf   (host_wr_buf),
        .host_wr_tile  (host_wr_tile),
        .host_wr_data  (host_wr_data),
        .host_rd_en    (host_rd_en),
        .host_rd_buf   (host_rd_buf),
        .host_rd_tile  (host_rd_tile),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

endmodule

`default_nettype wire

//--- design/relu_execution.sv
`timescale 1ns/1ps
`default_nettype none

`include "npu_defs_defs.svh"

// ReLU tile sequencer
// Reads each tile of the source buffer, clamps it, masks the tail
// beyond length and writes it to the same tile of the destination
module relu_execution (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  npu_pkg::buf_id_t    x_buffer_id,
    input  npu_pkg::buf_id_t    dest_buffer_id,
    input  npu_pkg::vec_len_t   length,
    output logic                done,
    output logic                busy,
    vec_buf_if.engine           mem
);
    import npu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_TILES,
        S_COMPLETE
    } state_t;

    // Counter wide enough for 32 tiles plus the end value
    localparam int CNT_W = $clog2(`NPU_TILES_PER_BUF) + 1;
    // Element offset wide enough for any in-range position
    localparam int OFF_W = $clog2(`NPU_MAX_ELEMS) + 1;

    state_t             state;
    buf_id_t            src_id;
    buf_id_t            dst_id;
    vec_len_t           len_q;
    logic [CNT_W-1:0]   tile_total;
    logic [CNT_W-1:0]   tile_cnt;
    logic [OFF_W-1:0]   elem_off;

    // Tile count for the start request, rounded up
    logic [OFF_W-1:0]   len_ceil;
    logic [CNT_W-1:0]   start_tiles;

    tile_t              act_tile;
    logic               last_tile;

    // Activation of the tile coming back from memory
    relu relu_unit (
        .in_tile  (mem.rd_data),
        .out_tile (act_tile)
    );

    always_comb begin
        len_ceil = {1'b0, length} + OFF_W'(`NPU_TILE_ELEMS - 1);
        start_tiles = CNT_W'(len_ceil / `NPU_TILE_ELEMS);
        // Zero length still writes one all-zero tile
        if (start_tiles == '0) begin
            start_tiles = CNT_W'(1);
        end
    end

    assign last_tile = (tile_cnt + CNT_W'(1)) >= tile_total;

    // Buffer ids are held for the whole operation
    assign mem.rd_buf  = src_id;
    assign mem.wr_buf  = dst_id;
    // Tile in flight, advanced as each response arrives
    assign mem.rd_tile = tile_idx_t'(tile_cnt);

    // Busy covers the done cycle as well
    assign busy = (state != S_IDLE) || done;

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_IDLE;
            done        <= 1'b0;
            mem.rd_en   <= 1'b0;
            mem.wr_en   <= 1'b0;
            mem.wr_tile <= '0;
            src_id      <= '0;
            dst_id      <= '0;
            len_q       <= '0;
            tile_total  <= '0;
            tile_cnt    <= '0;
            elem_off    <= '0;
        end else begin
            // Strobes last one cycle
            done      <= 1'b0;
            mem.rd_en <= 1'b0;
            mem.wr_en <= 1'b0;

            case (state)
                S_IDLE: begin
                    // done still high here, so a start in that cycle is dropped
                    if (start && !busy) begin
                        src_id     <= x_buffer_id;
                        dst_id     <= dest_buffer_id;
                        len_q      <= length;
                        tile_total <= start_tiles;
                        tile_cnt   <= '0;
                        elem_off   <= '0;
                        // Request tile 0 right away
                        mem.rd_en  <= 1'b1;
                        state      <= S_TILES;
                    end
                end

                S_TILES: begin
                    if (mem.rd_valid) begin
                        // Write back at the same tile position
                        mem.wr_en   <= 1'b1;
                        mem.wr_tile <= tile_idx_t'(tile_cnt);
                        tile_cnt    <= tile_cnt + CNT_W'(1);
                        elem_off    <= elem_off + OFF_W'(`NPU_TILE_ELEMS);
                        if (last_tile) begin
                            state <= S_COMPLETE;
                        end else begin
                            mem.rd_en <= 1'b1;
                        end
                    end
                end

                S_COMPLETE: begin
                    // Final write committed on this edge
                    done  <= 1'b1;
                    state <= S_IDLE;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Write payload, clamped and masked past length
    always_ff @(posedge clk) begin
        if (state == S_TILES && mem.rd_valid) begin
            for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
                if ((elem_off + OFF_W'(i)) < {1'b0, len_q}) begin
                    mem.wr_data.elems[i] <= act_tile.elems[i];
                end else begin
                    mem.wr_data.elems[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/vec_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

// Tile transfer bus between the ReLU engine and the vector memory
// Reads answer one cycle after rd_en with a single-cycle rd_valid
// Writes commit on the edge that samples wr_en
interface vec_buf_if (
    input logic clk
);
    import npu_pkg::*;

    // Read request and response
    logic       rd_en;
    buf_id_t    rd_buf;
    tile_idx_t  rd_tile;
    tile_t      rd_data;
    logic       rd_valid;

    // Write strobe and payload
    logic       wr_en;
    buf_id_t    wr_buf;
    tile_idx_t  wr_tile;
    tile_t      wr_data;

    // Execution unit side
    modport engine (
        input  clk,
        output rd_en, rd_buf, rd_tile,
        input  rd_data, rd_valid,
        output wr_en, wr_buf, wr_tile, wr_data
    );

    // Memory side
    modport memory (
        input  clk,
        input  rd_en, rd_buf, rd_tile,
        output rd_data, rd_valid,
        input  wr_en, wr_buf, wr_tile, wr_data
    );

endinterface

`default_nettype wire

//--- design/vector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "npu_defs_defs.svh"

// Vector memory, one tile word per entry
// Entry address is the buffer id above the tile index
// Engine and host each get a registered read port
// One shared write port, engine first
module vector_buffer (
    input  logic                clk,
    input  logic                rst,
    vec_buf_if.memory           mem,
    input  logic                host_wr_en,
    input  npu_pkg::buf_id_t    host_wr_buf,
    input  npu_pkg::tile_idx_t  host_wr_tile,
    input  npu_pkg::tile_t      host_wr_data,
    input  logic                host_rd_en,
    input  npu_pkg::buf_id_t    host_rd_buf,
    input  npu_pkg::tile_idx_t  host_rd_tile,
    output npu_pkg::tile_t      host_rd_data,
    output logic                host_rd_valid
);
    import npu_pkg::*;

    localparam int DEPTH  = `NPU_NUM_BUFFERS * `NPU_TILES_PER_BUF;
    localparam int ADDR_W = $clog2(DEPTH);

    // 1024 tiles of 256 bits
    tile_t tile_mem [0:DEPTH-1];

    logic [ADDR_W-1:0]  eng_rd_addr;
    logic [ADDR_W-1:0]  host_rd_addr;
    logic [ADDR_W-1:0]  wr_addr;
    logic               wr_any;
    tile_t              wr_word;

    assign eng_rd_addr  = {mem.rd_buf, mem.rd_tile};
    assign host_rd_addr = {host_rd_buf, host_rd_tile};

    // Write select
    // Engine strobe wins, host writes only happen while idle anyway
    always_comb begin
        wr_any = mem.wr_en || host_wr_en;
        if (mem.wr_en) begin
            wr_addr = {mem.wr_buf, mem.wr_tile};
            wr_word = mem.wr_data;
        end else begin
            wr_addr = {host_wr_buf, host_wr_tile};
            wr_word = host_wr_data;
        end
    end

    // Storage, contents survive reset
    always_ff @(posedge clk) begin
        if (wr_any) begin
            tile_mem[wr_addr] <= wr_word;
        end
    end

    // Engine read port
    // Old contents come back when a write hits the same entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem.rd_valid <= 1'b0;
            mem.rd_data  <= '0;
        end else begin
            mem.rd_valid <= mem.rd_en;
            if (mem.rd_en) begin
                mem.rd_data <= tile_mem[eng_rd_addr];
            end
        end
    end

    // Host read port, same one-cycle latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            host_rd_valid <= 1'b0;
            host_rd_data  <= '0;
        end else begin
            host_rd_valid <= host_rd_en;
            if (host_rd_en) begin
                host_rd_data <= tile_mem[host_rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- include/npu_defs_defs.svh
`ifndef NPU_DEFS_DEFS_SVH
`define NPU_DEFS_DEFS_SVH

// Sizing of the vector activation engine

// Bits per signed vector element
`define NPU_DATA_WIDTH 8

// Elements moved per tile transfer
`define NPU_TILE_ELEMS 32

// Flat tile word width
`define NPU_TILE_WIDTH (`NPU_DATA_WIDTH * `NPU_TILE_ELEMS)

// Number of vector buffers, sets the 5-bit buffer id
`define NPU_NUM_BUFFERS 32

// Tiles held per buffer, sets the 5-bit tile index
`define NPU_TILES_PER_BUF 32

// Largest vector a buffer can hold, in elements
`define NPU_MAX_ELEMS (`NPU_TILE_ELEMS * `NPU_TILES_PER_BUF)

`endif

//--- run_sim.sh
#!/bin/sh
# Compile and run the ReLU engine testbench with Verilator
set -e

cd "$(dirname "$0")"

# Build the simulation executable
verilator --binary --assert --top-module relu_accel_tb \
    -f verilog.f -o relu_accel_sim

# Run and keep the log
./obj_dir/relu_accel_sim > sim.log 2>&1
cat sim.log

# Result comes from the log
if grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- tests/relu_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "npu_defs_defs.svh"

module relu_accel_tb;
    import npu_pkg::*;

    localparam int DONE_TIMEOUT = 200;
    localparam int RD_TIMEOUT   = 10;
    localparam int QUIET_CYCLES = 8;
    localparam int EW           = `NPU_DATA_WIDTH;

    logic       clk;
    logic       rst;
    logic       start;
    buf_id_t    x_buffer_id;
    buf_id_t    dest_buffer_id;
    vec_len_t   length;
    logic       done;
    logic       busy;
    logic       host_wr_en;
    buf_id_t    host_wr_buf;
    tile_idx_t  host_wr_tile;
    tile_t      host_wr_data;
    logic       host_rd_en;
    buf_id_t    host_rd_buf;
    tile_idx_t  host_rd_tile;
    tile_t      host_rd_data;
    logic       host_rd_valid;

    // Mirror of the whole vector memory indexed by buffer id over tile index
    tile_t model [0:`NPU_NUM_BUFFERS*`NPU_TILES_PER_BUF-1];

    int          err_count;
    int          pass_count;
    int          fail_count;

    relu_accel_top UUT (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .x_buffer_id    (x_buffer_id),
        .dest_buffer_id (dest_buffer_id),
        .length         (length),
        .done           (done),
        .busy           (busy),
        .host_wr_en     (host_wr_en),
        .host_wr_buf    (host_wr_buf),
        .host_wr_tile   (host_wr_tile),
        .host_wr_data   (host_wr_data),
        .host_rd_en     (host_rd_en),
        .host_rd_buf    (host_rd_buf),
        .host_rd_tile   (host_rd_tile),
        .host_rd_data   (host_rd_data),
        .host_rd_valid  (host_rd_valid)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // Step 1 ns past the next rising edge where outputs have settled
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic tile_t random_tile();
        tile_t t;
        for (int w = 0; w < `NPU_TILE_WIDTH / 32; w++) begin
            t.raw[32*w +: 32] = $urandom;
        end
        return t;
    endfunction

    // Host write mirrored into the model
    task automatic write_tile(input buf_id_t b, input tile_idx_t t, input tile_t data);
        host_wr_en   = 1'b1;
        host_wr_buf  = b;
        host_wr_tile = t;
        host_wr_data = data;
        tick();
        host_wr_en   = 1'b0;
        model[{b, t}] = data;
    endtask

    // Host read that waits for the valid flag
    task automatic read_tile(input string name, input buf_id_t b, input tile_idx_t t,
                             output tile_t data);
        int k;
        host_rd_en   = 1'b1;
        host_rd_buf  = b;
        host_rd_tile = t;
        tick();
        host_rd_en = 1'b0;
        k = 0;
        while (!host_rd_valid && k < RD_TIMEOUT) begin
            tick();
            k++;
        end
        if (!host_rd_valid) begin
            $display("%s: no read response from buffer %0d tile %0d", name, b, t);
            err_count++;
        end
        data = host_rd_data;
    endtask

    // Random contents in every tile of every buffer
    task automatic fill_memory();
        for (int b = 0; b < `NPU_NUM_BUFFERS; b++) begin
            for (int t = 0; t < `NPU_TILES_PER_BUF; t++) begin
                write_tile(buf_id_t'(b), tile_idx_t'(t), random_tile());
            end
        end
    endtask

    // Expected tile after clamping and zeroing everything at or past len
    function automatic tile_t activate_tile(input tile_t src, input int t, input vec_len_t len);
        tile_t res;
        res = '0;
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            if (t * `NPU_TILE_ELEMS + i < int'(len)) begin
                // Non-negative elements pass through
                if (!src.raw[EW*i + EW-1]) begin
                    res.raw[EW*i +: EW] = src.raw[EW*i +: EW];
                end
            end
        end
        return res;
    endfunction

    // Tiles touched by len rounded up with a minimum of one
    function automatic int tile_count(input vec_len_t len);
        int n;
        n = (int'(len) + `NPU_TILE_ELEMS - 1) / `NPU_TILE_ELEMS;
        if (n == 0) begin
            n = 1;
        end
        return n;
    endfunction

    task automatic apply_op_model(input buf_id_t src, input buf_id_t dst, input vec_len_t len);
        tile_t tmp [0:`NPU_TILES_PER_BUF-1];
        int n;
        n = tile_count(len);
        // All sources first so in-place works on original data
        for (int t = 0; t < n; t++) begin
            tmp[t] = activate_tile(model[{src, tile_idx_t'(t)}], t, len);
        end
        for (int t = 0; t < n; t++) begin
            model[{dst, tile_idx_t'(t)}] = tmp[t];
        end
    endtask

    // One operation with timing checks
    // Restart pulses a second start mid-operation and again in the done cycle
    task automatic run_op(input string name, input buf_id_t src, input buf_id_t dst,
                          input vec_len_t len, input bit restart);
        int n;
        int k;
        n = tile_count(len);
        x_buffer_id    = src;
        dest_buffer_id = dst;
        length         = len;
        start          = 1'b1;
        tick();
        start = 1'b0;
        k = 0;
        while (!done && k < DONE_TIMEOUT) begin
            assert (busy) else begin
                $display("[ERROR] %s busy at cycle %0d expected 1 actual %0b", name, k, busy);
                err_count++;
            end
            if (restart && k == 1) begin
                dest_buffer_id = dst + buf_id_t'(1);
                length         = '0;
                start          = 1'b1;
            end else begin
                start = 1'b0;
            end
            tick();
            k++;
        end
        start = 1'b0;
        if (!done) begin
            $display("%s: done did not arrive within %0d cycles", name, DONE_TIMEOUT);
            err_count++;
        end else begin
            assert (k == 2 * n + 1) else begin
                $display("[ERROR] %s done cycle expected %0d actual %0d", name, 2 * n + 1, k);
                err_count++;
            end
            assert (busy) else begin
                $display("[ERROR] %s busy with done expected 1 actual %0b", name, busy);
                err_count++;
            end
            // Busy still covers this cycle so this start must be dropped
            if (restart) begin
                start = 1'b1;
            end
        end
        tick();
        start = 1'b0;
        assert (!done && !busy) else begin
            $display("[ERROR] %s done,busy after pulse expected 0,0 actual %0b,%0b",
                     name, done, busy);
            err_count++;
        end
        // No late second pulse
        repeat (QUIET_CYCLES) begin
            tick();
            assert (!done) else begin
                $display("[ERROR] %s extra done expected 0 actual %0b", name, done);
                err_count++;
            end
        end
        apply_op_model(src, dst, len);
    endtask

    // Read back every tile of every buffer against the model
    task automatic compare_memory(input string name);
        tile_t got;
        tile_t exp;
        for (int b = 0; b < `NPU_NUM_BUFFERS; b++) begin
            for (int t = 0; t < `NPU_TILES_PER_BUF; t++) begin
                read_tile(name, buf_id_t'(b), tile_idx_t'(t), got);
                exp = model[{buf_id_t'(b), tile_idx_t'(t)}];
                assert (got == exp) else begin
                    $display("[ERROR] %s buffer %0d tile %0d expected %h actual %h",
                             name, b, t, exp.raw, got.raw);
                    err_count++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (err_count == mark) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", name, err_count - mark);
        end
    endtask

    initial begin
        buf_id_t  src;
        buf_id_t  dst;
        int       mark;
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        x_buffer_id    = '0;
        dest_buffer_id = '0;
        length         = '0;
        host_wr_en     = 1'b0;
        host_wr_buf    = '0;
        host_wr_tile   = '0;
        host_wr_data   = '0;
        host_rd_en     = 1'b0;
        host_rd_buf    = '0;
        host_rd_tile   = '0;
        err_count      = 0;
        pass_count     = 0;
        fail_count     = 0;
        void'($urandom(32'hdce8));

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        mark = err_count;
        assert (!done && !busy && !host_rd_valid) else begin
            $display("[ERROR] reset_state done,busy,rd_valid expected 0,0,0 actual %0b,%0b,%0b",
                     done, busy, host_rd_valid);
            err_count++;
        end
        finish_test("reset_state", mark);

        fill_memory();

        // Exactly one tile with the rest of the destination untouched
        mark = err_count;
        src = buf_id_t'($urandom);
        dst = src + buf_id_t'(1 + ($urandom % 31));
        run_op("full_tile", src, dst, vec_len_t'(32), 1'b0);
        compare_memory("full_tile");
        finish_test("full_tile", mark);

        // Padding inside tile 0
        mark = err_count;
        src = buf_id_t'($urandom);
        dst = src + buf_id_t'(1 + ($urandom % 31));
        run_op("partial_tile", src, dst, vec_len_t'(1 + ($urandom % 31)), 1'b0);
        compare_memory("partial_tile");
        finish_test("partial_tile", mark);

        // Padding in the last of several tiles
        mark = err_count;
        src = buf_id_t'($urandom);
        dst = src + buf_id_t'(1 + ($urandom % 31));
        run_op("multi_tile", src, dst, vec_len_t'(33 + ($urandom % 991)), 1'b0);
        compare_memory("multi_tile");
        finish_test("multi_tile", mark);

        // Distinct buffers, every other buffer unchanged
        mark = err_count;
        src = buf_id_t'($urandom);
        dst = src + buf_id_t'(1 + ($urandom % 31));
        run_op("separate_buffers", src, dst, vec_len_t'(1 + ($urandom % 1023)), 1'b0);
        compare_memory("separate_buffers");
        finish_test("separate_buffers", mark);

        // Source and destination are the same buffer
        mark = err_count;
        src = buf_id_t'($urandom);
        run_op("in_place", src, src, vec_len_t'(1 + ($urandom % 1023)), 1'b0);
        compare_memory("in_place");
        finish_test("in_place", mark);

        // Start while busy must not launch a second operation
        mark = err_count;
        src = buf_id_t'($urandom);
        dst = src + buf_id_t'(1 + ($urandom % 31));
        run_op("restart_ignored", src, dst, vec_len_t'(100 + ($urandom % 900)), 1'b1);
        compare_memory("restart_ignored");
        finish_test("restart_ignored", mark);

        // One all-zero tile at destination tile 0
        mark = err_count;
        src = buf_id_t'($urandom);
        dst = src + buf_id_t'(1 + ($urandom % 31));
        run_op("zero_length", src, dst, vec_len_t'(0), 1'b0);
        compare_memory("zero_length");
        finish_test("zero_length", mark);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
design/npu_pkg.sv
design/vec_buf_if.sv
design/relu.sv
design/relu_execution.sv
design/vector_buffer.sv
design/relu_accel_top.sv
tests/relu_accel_tb.sv
